// ==== cic_comb_chain.sv ====
// low-rate differentiator half of the CIC interpolator, four comb stages advanced by data request
module cic_comb_chain (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                data_req,
	input  cic_sig_pkg::sample_t signal_in,
	output cic_sig_pkg::comb_t   comb_out
);

	// previous input of each stage
	cic_sig_pkg::comb_t delay_q [cic_rate_pkg::num_stages];

	// difference output of each stage
	cic_sig_pkg::comb_t diff_q [cic_rate_pkg::num_stages];

	// input of each stage
	// stage zero sees the sample, the others the stage before
	cic_sig_pkg::comb_t stage_in [cic_rate_pkg::num_stages];

	always_comb begin
		// sign extend the sample into the comb width
		stage_in[0] = {{(cic_sig_pkg::comb_w - cic_sig_pkg::sample_w){signal_in[cic_sig_pkg::sample_w-1]}},
			signal_in};
		for (int k = 1; k < cic_rate_pkg::num_stages; k++) begin
			stage_in[k] = diff_q[k-1];
		end
	end

	// all stages update together on a request
	// a sample needs four requests to reach the last stage
	always_ff @(posedge clock) begin
		if (!rst_n || !enable) begin
			for (int k = 0; k < cic_rate_pkg::num_stages; k++) begin
				delay_q[k] <= '0;
				diff_q[k]  <= '0;
			end
		end else if (data_req) begin
			for (int k = 0; k < cic_rate_pkg::num_stages; k++) begin
				delay_q[k] <= stage_in[k];
				// x[n] - x[n-1], wraps in the comb width
				diff_q[k]  <= stage_in[k] - delay_q[k];
			end
		end
	end

	// last stage feeds the upsampler
	assign comb_out = diff_q[cic_rate_pkg::num_stages-1];

endmodule

// ==== cic_int_shifter.sv ====
// gain correction of the CIC interpolator that picks sixteen integrator bits by the ratio's bit gain
module cic_int_shifter (
	input  cic_rate_pkg::rate_t  rate,
	input  cic_sig_pkg::acc_t    signal_in,
	output cic_sig_pkg::sample_t signal_out
);

	// bit gain of a ratio R for an order N filter
	// powers of two give exactly (N-1)*log2(R)
	// other ratios use the rounded band of the same growth
	// unsupported ratios fall back to the largest shift
	function automatic cic_rate_pkg::gain_t bit_gain(input cic_rate_pkg::rate_t ratio);
		cic_rate_pkg::gain_t gain;
		case (ratio) inside
			4:   gain = cic_rate_pkg::gain_t'(2 * (cic_rate_pkg::num_stages - 1));
			8:   gain = cic_rate_pkg::gain_t'(3 * (cic_rate_pkg::num_stages - 1));
			16:  gain = cic_rate_pkg::gain_t'(4 * (cic_rate_pkg::num_stages - 1));
			32:  gain = cic_rate_pkg::gain_t'(5 * (cic_rate_pkg::num_stages - 1));
			64:  gain = cic_rate_pkg::gain_t'(6 * (cic_rate_pkg::num_stages - 1));
			128: gain = cic_rate_pkg::gain_t'(7 * (cic_rate_pkg::num_stages - 1));

			// bands between the powers
			5:         gain = 5'd7;
			6:         gain = 5'd8;
			7:         gain = 5'd9;
			[9:10]:    gain = 5'd10;
			[11:12]:   gain = 5'd11;
			[13:15]:   gain = 5'd12;
			[17:20]:   gain = 5'd13;
			[21:25]:   gain = 5'd14;
			[26:31]:   gain = 5'd15;
			[33:40]:   gain = 5'd16;
			[41:50]:   gain = 5'd17;
			[51:63]:   gain = 5'd18;
			[65:80]:   gain = 5'd19;
			[81:101]:  gain = 5'd20;

			default:   gain = cic_rate_pkg::gain_t'(cic_rate_pkg::max_bitgain);
		endcase
		return gain;
	endfunction

	// interpolation ratio
	// wraps to zero for rate 255
	cic_rate_pkg::rate_t ratio;

	// shift that cancels the filter gain
	cic_rate_pkg::gain_t shift;

	assign ratio = rate + cic_rate_pkg::rate_t'(1);
	assign shift = bit_gain(ratio);

	// one fixed slice per shift value
	// truncates with no rounding or saturation
	always_comb begin
		case (shift)
			// power of two ratios
			5'd6:  signal_out = signal_in[6  +: cic_sig_pkg::sample_w];
			5'd9:  signal_out = signal_in[9  +: cic_sig_pkg::sample_w];
			5'd12: signal_out = signal_in[12 +: cic_sig_pkg::sample_w];
			5'd15: signal_out = signal_in[15 +: cic_sig_pkg::sample_w];
			5'd18: signal_out = signal_in[18 +: cic_sig_pkg::sample_w];

			// band entries
			5'd7:  signal_out = signal_in[7  +: cic_sig_pkg::sample_w];
			5'd8:  signal_out = signal_in[8  +: cic_sig_pkg::sample_w];
			5'd10: signal_out = signal_in[10 +: cic_sig_pkg::sample_w];
			5'd11: signal_out = signal_in[11 +: cic_sig_pkg::sample_w];
			5'd13: signal_out = signal_in[13 +: cic_sig_pkg::sample_w];
			5'd14: signal_out = signal_in[14 +: cic_sig_pkg::sample_w];
			5'd16: signal_out = signal_in[16 +: cic_sig_pkg::sample_w];
			5'd17: signal_out = signal_in[17 +: cic_sig_pkg::sample_w];
			5'd19: signal_out = signal_in[19 +: cic_sig_pkg::sample_w];
			5'd20: signal_out = signal_in[20 +: cic_sig_pkg::sample_w];

			// ratio 128 and every unsupported ratio
			// top sixteen bits of the accumulator
			default: signal_out = signal_in[cic_rate_pkg::max_bitgain +: cic_sig_pkg::sample_w];
		endcase
	end

endmodule

// ==== cic_integrator_chain.sv ====
// high-rate half of the CIC interpolator, zero stuffing followed by four integrators
module cic_integrator_chain (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               enable,
	input  logic               sample_strobe,
	input  logic               inject,
	input  cic_sig_pkg::comb_t comb_out,
	output cic_sig_pkg::acc_t  integ_out
);

	// accumulators, stage zero first
	cic_sig_pkg::acc_t integ_q [cic_rate_pkg::num_stages];

	// comb result widened to the accumulator
	cic_sig_pkg::acc_t comb_ext;

	// upsampler output
	// one real sample per period, zeros in between
	cic_sig_pkg::acc_t stuffed;

	assign comb_ext = {{(cic_sig_pkg::acc_w - cic_sig_pkg::comb_w){comb_out[cic_sig_pkg::comb_w-1]}},
		comb_out};

	assign stuffed = inject ? comb_ext : '0;

	// every stage adds the old value of the stage before it
	// so all four move at one edge and several samples are in flight
	// sums wrap modulo 2^acc_w, which the combs undo
	always_ff @(posedge clock) begin
		if (!rst_n || !enable) begin
			for (int k = 0; k < cic_rate_pkg::num_stages; k++) begin
				integ_q[k] <= '0;
			end
		end else if (sample_strobe) begin
			integ_q[0] <= integ_q[0] + stuffed;
			for (int k = 1; k < cic_rate_pkg::num_stages; k++) begin
				integ_q[k] <= integ_q[k] + integ_q[k-1];
			end
		end
	end

	// full-width result, gain still uncorrected
	assign integ_out = integ_q[cic_rate_pkg::num_stages-1];

endmodule

// ==== cic_interp.f ====
cic_sig_pkg.sv
cic_rate_pkg.sv
cic_interp_ctrl.sv
cic_comb_chain.sv
cic_integrator_chain.sv
cic_int_shifter.sv
cic_interp.sv
tb_cic_interp.sv

// ==== cic_interp.sv ====
// top of the fixed order-four CIC interpolator for a transmit path, one sample in per data request
module cic_interp (
	input  logic                 clock,
	input  logic                 rst_n,
	input  logic                 enable,
	// ratio minus one, only changed while enable is low
	input  cic_rate_pkg::rate_t  rate,
	// one pulse per output sample
	input  logic                 sample_strobe,
	// valid whenever data_req is high
	input  cic_sig_pkg::sample_t signal_in,
	output logic                 data_req,
	output cic_sig_pkg::sample_t signal_out
);

	// comb result goes into the upsampler on this strobe
	logic inject;

	// last comb stage
	cic_sig_pkg::comb_t comb_out;

	// last integrator, full growth
	cic_sig_pkg::acc_t integ_out;

	// period counter, owns the ratio timing
	cic_interp_ctrl cic_interp_ctrl_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.enable        (enable),
		.sample_strobe (sample_strobe),
		.rate          (rate),
		.data_req      (data_req),
		.inject        (inject)
	);

	// differentiators at the input rate
	cic_comb_chain cic_comb_chain_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.enable    (enable),
		.data_req  (data_req),
		.signal_in (signal_in),
		.comb_out  (comb_out)
	);

	// zero stuffing and integrators at the output rate
	cic_integrator_chain cic_integrator_chain_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.enable        (enable),
		.sample_strobe (sample_strobe),
		.inject        (inject),
		.comb_out      (comb_out),
		.integ_out     (integ_out)
	);

	// gain correction back to sixteen bits
	cic_int_shifter cic_int_shifter_inst (
		.rate       (rate),
		.signal_in  (integ_out),
		.signal_out (signal_out)
	);

endmodule

// ==== cic_interp_ctrl.sv ====
// interpolation rhythm of the CIC filter, derives data request and comb injection from the strobe
module cic_interp_ctrl (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                sample_strobe,
	input  cic_rate_pkg::rate_t rate,
	output logic                data_req,
	output logic                inject
);

	// position inside one interpolation period
	// counts 0 .. rate, one step per high-rate strobe
	cic_rate_pkg::rate_t phase;

	// phase at the end of the period
	logic phase_last;

	// phase decodes
	logic phase_zero;
	logic phase_one;

	assign phase_last = (phase == rate);
	assign phase_zero = (phase == '0);
	assign phase_one  = (phase == cic_rate_pkg::rate_t'(1));

	// phase counter
	// held at zero while disabled so the first strobe after enable asks for data
	always_ff @(posedge clock) begin
		if (!rst_n || !enable) begin
			phase <= '0;
		end else if (sample_strobe) begin
			if (phase_last) begin
				// wrap back, a new input sample is due
				phase <= '0;
			end else begin
				phase <= phase + cic_rate_pkg::rate_t'(1);
			end
		end
	end

	// request a new input sample on the strobe that opens each period
	// same cycle as the strobe, so the comb chain loads at this edge
	// enable keeps the request quiet while strobes run on a stopped filter
	assign data_req = enable && sample_strobe && phase_zero;

	// the strobe after a request is the one that feeds the new comb result
	// all other strobes of the period stuff zeros into the integrators
	assign inject = phase_one;

endmodule

// ==== cic_rate_pkg.sv ====
// filter order, rate limits and rate types of the CIC interpolator, referenced by scoped name
package cic_rate_pkg;

	// filter order N, same count of combs and integrators
	localparam int num_stages = 4;

	// largest supported ratio is 128
	localparam int log2_max_rate = 7;

	// gain of the ratio to the power N, minus one stage that the comb growth covers
	localparam int max_bitgain = (num_stages - 1) * log2_max_rate;

	// smallest usable rate setting, ratio of 4
	localparam int min_rate = 3;

	// interpolation ratio minus one
	typedef logic [7:0] rate_t;

	// shift applied by the gain correction
	typedef logic [4:0] gain_t;

endpackage

// ==== cic_sig_pkg.sv ====
// sample, comb and accumulator widths of the CIC interpolator datapath, referenced by scoped name
package cic_sig_pkg;

	// width of one sample entering or leaving the filter
	localparam int sample_w = 16;

	// comb stages grow one bit each
	// four stages on top of the sample width
	localparam int comb_w = 20;

	// integrators must carry the full bit gain of the largest ratio
	// 16 bits of sample plus 21 bits of growth
	localparam int acc_w = 37;

	// one input or output sample
	typedef logic [sample_w-1:0] sample_t;

	// one comb stage result at the low rate
	typedef logic [comb_w-1:0] comb_t;

	// one integrator register at the high rate
	typedef logic [acc_w-1:0] acc_t;

endpackage

// ==== tb_cic_interp.sv ====
// CIC interpolator testbench that drives strobes and samples and checks against a bit-true model
module tb_cic_interp;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clock_period = 8;

	// strobes issued over all tests to size the watchdog limit
	localparam int total_strobes = 20 + 40 + 160 + 400 + 200 + 300;
	localparam int margin_ns = 2000;

	// DUT inputs
	logic                 clock = 1'b0;
	logic                 rst_n;
	logic                 enable;
	cic_rate_pkg::rate_t  rate;
	logic                 sample_strobe;
	cic_sig_pkg::sample_t signal_in;

	// DUT outputs
	logic                 data_req;
	cic_sig_pkg::sample_t signal_out;

	// model state mirroring the filter registers
	int                 m_phase = 0;
	cic_sig_pkg::comb_t m_delay [cic_rate_pkg::num_stages];
	cic_sig_pkg::comb_t m_diff [cic_rate_pkg::num_stages];
	cic_sig_pkg::acc_t  m_integ [cic_rate_pkg::num_stages];

	// bookkeeping
	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          req_seen = 0;
	bit          check_on = 1'b0;
	logic [31:0] lfsr_state = 32'd25;

	// expected values of the current cycle
	logic                 exp_req;
	cic_sig_pkg::sample_t exp_out;

	cic_interp cic_interp_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.enable        (enable),
		.rate          (rate),
		.sample_strobe (sample_strobe),
		.signal_in     (signal_in),
		.data_req      (data_req),
		.signal_out    (signal_out)
	);

	always #(clock_period / 2) clock = ~clock;

	// right-shift Galois LFSR stepped once per bit drawn
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hA300_0000;
		end
		return s >> 1;
	endfunction

	// bit gain of a ratio as the smallest g with ratio^(N-1) <= 2^g
	// ratios outside 4 .. 128 take the top shift
	function automatic int ratio_gain(input int ratio);
		longint growth;
		int     g;
		if (ratio < 4 || ratio > 128) begin
			return cic_rate_pkg::max_bitgain;
		end
		growth = 1;
		for (int s = 1; s < cic_rate_pkg::num_stages; s++) begin
			growth = growth * ratio;
		end
		g = 0;
		while ((longint'(1) << g) < growth) begin
			g++;
		end
		return g;
	endfunction

	// expected output as a truncating slice of an integrator word
	function automatic cic_sig_pkg::sample_t expected_out(input cic_sig_pkg::acc_t acc,
			input cic_rate_pkg::rate_t r);
		int shift;
		shift = ratio_gain(int'(r) + 1);
		return cic_sig_pkg::sample_t'(acc >> shift);
	endfunction

	// advance the model by the clock edge that follows this cycle's inputs
	task automatic model_step;
		cic_sig_pkg::comb_t stage_in;
		if (!rst_n || !enable) begin
			m_phase = 0;
			for (int k = 0; k < cic_rate_pkg::num_stages; k++) begin
				m_delay[k] = '0;
				m_diff[k]  = '0;
				m_integ[k] = '0;
			end
		end else if (sample_strobe) begin
			// integrators first since they see the old comb output
			for (int k = cic_rate_pkg::num_stages - 1; k > 0; k--) begin
				m_integ[k] = m_integ[k] + m_integ[k-1];
			end
			if (m_phase == 1) begin
				m_integ[0] = m_integ[0] + cic_sig_pkg::acc_t'($signed(m_diff[cic_rate_pkg::num_stages-1]));
			end
			// combs only on a request with the top stage first so it takes the old lower stage
			if (m_phase == 0) begin
				for (int k = cic_rate_pkg::num_stages - 1; k >= 0; k--) begin
					if (k == 0) begin
						stage_in = cic_sig_pkg::comb_t'($signed(signal_in));
					end else begin
						stage_in = m_diff[k-1];
					end
					m_diff[k]  = stage_in - m_delay[k];
					m_delay[k] = stage_in;
				end
			end
			if (m_phase == int'(rate)) begin
				m_phase = 0;
			end else begin
				m_phase++;
			end
		end
	endtask

	// compare at the falling edge where inputs and outputs are settled
	always @(negedge clock) begin
		if (check_on) begin
			exp_req = enable && sample_strobe && (m_phase == 0);
			exp_out = expected_out(m_integ[cic_rate_pkg::num_stages-1], rate);
			assert (data_req === exp_req) else begin
				$display("MISMATCH data_req at %0t: expected %h, got %h", $time, exp_req, data_req);
				errors++;
			end
			assert (signal_out === exp_out) else begin
				$display("MISMATCH signal_out at %0t: expected %h, got %h", $time, exp_out,
					signal_out);
				errors++;
			end
			if (data_req === 1'b1) begin
				req_seen++;
			end
		end
		model_step();
	end

	// inputs move 1 ns after the rising edge
	task automatic next_cycle;
		@(posedge clock);
		#1;
	endtask

	task automatic draw_sample(output cic_sig_pkg::sample_t v);
		for (int b = 0; b < cic_sig_pkg::sample_w; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v[b] = lfsr_state[0];
		end
	endtask

	// one strobe every second cycle with a new sample for each
	task automatic run_strobes(input int count, input bit random_on, input cic_sig_pkg::sample_t hold);
		cic_sig_pkg::sample_t v;
		for (int i = 0; i < count; i++) begin
			if (random_on) begin
				draw_sample(v);
			end else begin
				v = hold;
			end
			next_cycle();
			sample_strobe = 1'b1;
			signal_in = v;
			next_cycle();
			sample_strobe = 1'b0;
		end
	endtask

	// rate may only move while the filter is stopped
	task automatic configure_rate(input cic_rate_pkg::rate_t r);
		next_cycle();
		enable = 1'b0;
		next_cycle();
		rate = r;
		next_cycle();
		enable = 1'b1;
	endtask

	task automatic expect_output(input cic_sig_pkg::sample_t want);
		@(negedge clock);
		assert (signal_out === want) else begin
			$display("MISMATCH signal_out at %0t: expected %h, got %h", $time, want, signal_out);
			errors++;
		end
	endtask

	task automatic expect_requests(input int want);
		assert (req_seen == want) else begin
			$display("wrong number of data requests: expected %0d, saw %0d", want, req_seen);
			errors++;
		end
	endtask

	task automatic start_test;
		errors_at_start = errors;
		req_seen = 0;
	endtask

	task automatic finish_test(input int id, input string name);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %0d %s: ok", id, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", id, name, errors - errors_at_start);
		end
	endtask

	// watchdog allows two cycles per strobe plus room for reset and rate changes
	initial begin
		#(total_strobes * 2 * clock_period + margin_ns);
		$display("timeout: the tests did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		enable = 1'b0;
		rate = cic_rate_pkg::rate_t'(7);
		sample_strobe = 1'b0;
		signal_in = '0;
		repeat (4) next_cycle();
		rst_n = 1'b1;
		check_on = 1'b1;

		// strobes with the filter stopped leave everything still
		start_test();
		run_strobes(20, 1'b0, 16'h7fff);
		expect_requests(0);
		expect_output('0);
		finish_test(1, "idle while disabled");

		// ratio 8 asks for data on strobes 0 8 16 24 and 32
		start_test();
		configure_rate(7);
		run_strobes(40, 1'b0, 16'h0123);
		expect_requests(5);
		finish_test(2, "request rhythm at rate 7");

		// ratio 16 where a 12 bit shift cancels the gain of 16^3
		start_test();
		configure_rate(15);
		run_strobes(160, 1'b0, 16'h1000);
		expect_output(16'h1000);
		finish_test(3, "dc gain at rate 15");

		start_test();
		configure_rate(7);
		run_strobes(400, 1'b1, '0);
		finish_test(4, "random input at rate 7");

		// ratio 10 from the band table
		start_test();
		configure_rate(9);
		run_strobes(200, 1'b1, '0);
		finish_test(5, "random input at rate 9");

		// stopping mid-stream must clear all state
		start_test();
		next_cycle();
		enable = 1'b0;
		next_cycle();
		expect_output('0);
		configure_rate(31);
		run_strobes(100, 1'b0, '0);
		expect_output('0);
		run_strobes(200, 1'b1, '0);
		finish_test(6, "restart at rate 31");

		$display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
